// ==== verification/drpGolden.txt ====
// group port we addr wdata rdata delay, all hex, one transaction per line
// Port f asks for a reset before its group, delay 0 picks a random delay
// Single write on an idle interconnect
0 0 1 010 a5a5 0000 2
// Reads, other ports hold their data
1 1 0 020 0000 1234 1
2 2 0 030 0000 beef 0
// Three at once, port 0 waits long so the others stay pending
3 0 0 100 0000 0f0f 8
3 1 1 101 5a5a 0000 3
3 2 0 102 0000 c3c3 1
4 1 0 200 0000 7777 0
// Pointer now past port 1
5 0 1 300 1111 0000 0
5 1 0 301 0000 2222 0
5 2 0 302 0000 3333 5
6 0 0 400 0000 4444 6
6 2 1 401 9999 0000 0
// Reset mid run, port 0 must win first
7 f 0 000 0000 0000 0
7 0 0 500 0000 5555 2
7 1 1 501 6666 0000 0
7 2 0 502 0000 6666 4
8 1 0 600 0000 8888 0

// ==== files.f ====
common/drpPkg.sv
src/drpRequestLatch.sv
drpMaster/drpArbiter.sv
drpMaster/drpMasterSequencer.sv
src/drpResponseRouter.sv
src/drpInterconnect.sv
verification/drpChecker.sv
verification/tbDrpInterconnect.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tbDrpInterconnect
FILELIST = files.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJDIR)

// ==== verification/tbDrpInterconnect.sv ====
`timescale 1ns/100ps

module tbDrpInterconnect;

  import drpPkg::*;

  localparam int          NumPorts  = DEF_PORTS;
  localparam int          AddrWidth = DEF_ADDR_W;
  localparam int          DataWidth = DEF_DATA_W;
  localparam int          Fields    = 7;
  localparam int          MaxLines  = 64;
  localparam logic [15:0] ResetMark = 16'h000f;
  localparam logic [15:0] EndMark   = 16'hffff;

  logic                 drpClk = 1'b0;
  logic                 rst;
  logic [NumPorts-1:0]  sEn;
  drpReqT               sReq [NumPorts];
  logic [NumPorts-1:0]  sRdy;
  logic [DataWidth-1:0] sDo [NumPorts];
  logic                 mEn;
  logic                 mWe;
  logic [AddrWidth-1:0] mAddr;
  logic [DataWidth-1:0] mDo;
  logic                 mRdy = 1'b0;
  logic [DataWidth-1:0] mDi = '0;
  logic                 endOfTest;
  int                   mismatchCount;
  int                   otherCount;

  // Golden lines of seven words each
  logic [15:0] gold [Fields*MaxLines];
  int          lineCount = 0;
  int          curFirst = 0;
  int          curLast = 0;
  int          rdySeen = 0;
  int          setupErrors = 0;
  logic [15:0] tgtData;
  int          tgtDelay;

  always #5 drpClk = ~drpClk;

  drpInterconnect #(
    .NumPorts  (NumPorts),
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth)
  ) i_drpInterconnect (
    .drpClk (drpClk),
    .rst    (rst),
    .sEn    (sEn),
    .sReq   (sReq),
    .sRdy   (sRdy),
    .sDo    (sDo),
    .mEn    (mEn),
    .mWe    (mWe),
    .mAddr  (mAddr),
    .mDo    (mDo),
    .mRdy   (mRdy),
    .mDi    (mDi)
  );

  drpChecker #(
    .NumPorts  (NumPorts),
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth)
  ) i_drpChecker (
    .drpClk        (drpClk),
    .rst           (rst),
    .sEn           (sEn),
    .sReq          (sReq),
    .sRdy          (sRdy),
    .sDo           (sDo),
    .mEn           (mEn),
    .mWe           (mWe),
    .mAddr         (mAddr),
    .mDo           (mDo),
    .mRdy          (mRdy),
    .mDi           (mDi),
    .endOfTest     (endOfTest),
    .mismatchCount (mismatchCount),
    .otherCount    (otherCount)
  );

  //////////////////////////////
  // DRP target model
  //////////////////////////////

  // Finds the issued line of the running group by its contents
  function automatic logic issueMatches(int line);
    return gold[line*Fields+1] != ResetMark && gold[line*Fields+2][0] == mWe &&
           gold[line*Fields+3][AddrWidth-1:0] == mAddr && gold[line*Fields+4] == mDo;
  endfunction

  always begin
    @(negedge drpClk);
    if (mEn) begin
      tgtData  = '0;
      tgtDelay = 1;
      for (int i = curFirst; i < curLast; i++) begin
        if (issueMatches(i)) begin
          tgtData  = gold[i*Fields+5];
          tgtDelay = int'(gold[i*Fields+6]);
        end
      end
      if (tgtDelay == 0) begin
        tgtDelay = 1 + int'($urandom % 8);
      end
      @(posedge drpClk);
      repeat (tgtDelay - 1) @(posedge drpClk);
      #1;
      mRdy = 1'b1;
      mDi  = tgtData;
      @(posedge drpClk);
      #1;
      mRdy = 1'b0;
      // Data is only valid alongside the ready pulse
      mDi  = ~tgtData;
    end
  end

  always @(negedge drpClk) begin
    rdySeen <= rdySeen + $countones(sRdy);
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic printErrorCounts();
    $display("Errors: %0d mismatches, %0d other failures", mismatchCount,
             otherCount + setupErrors);
  endtask

  // Drives one strobe for every port line of a group
  task automatic strobeLines(input int first, input int last, output int count);
    int port;
    count = 0;
    for (int i = first; i < last; i++) begin
      port = int'(gold[i*Fields+1]);
      if (port < NumPorts) begin
        sEn[port]       = 1'b1;
        sReq[port].we   = gold[i*Fields+2][0];
        sReq[port].addr = gold[i*Fields+3][AddrWidth-1:0];
        sReq[port].di   = gold[i*Fields+4];
        count++;
      end else if (gold[i*Fields+1] != ResetMark) begin
        $display("Golden line %0d names port %0d, which does not exist", i, port);
        setupErrors++;
      end
    end
    @(posedge drpClk);
    #1;
    sEn = '0;
    // Request fields carry no meaning once the strobe is gone
    for (int p = 0; p < NumPorts; p++) begin
      sReq[p] = drpReqT'(~sReq[p]);
    end
  endtask

  // Strobes one group together and waits for all its ready pulses
  task automatic runGroup(input int first, input int last);
    int   target;
    int   count;
    logic resetHit;
    resetHit = 1'b0;
    for (int i = first; i < last; i++) begin
      if (gold[i*Fields+1] == ResetMark) begin
        resetHit = 1'b1;
      end
    end
    curFirst = first;
    curLast  = last;
    if (resetHit) begin
      // Reset lands on the grant of requests already pending
      strobeLines(first, last, count);
      @(posedge drpClk);
      #1;
      rst = 1'b1;
      repeat (2) @(posedge drpClk);
      #1;
      rst = 1'b0;
    end
    target = rdySeen;
    strobeLines(first, last, count);
    target += count;
    while (rdySeen < target) begin
      @(posedge drpClk);
    end
    #1;
  endtask

  initial begin
    int first;
    int last;
    rst       = 1'b1;
    sEn       = '0;
    endOfTest = 1'b0;
    for (int p = 0; p < NumPorts; p++) begin
      sReq[p] = '0;
    end
    void'($urandom(32'h7e6a7022));
    for (int i = 0; i < Fields*MaxLines; i++) begin
      gold[i] = EndMark;
    end
    $readmemh("verification/drpGolden.txt", gold);
    while (lineCount < MaxLines && gold[lineCount*Fields] != EndMark) begin
      lineCount++;
    end
    if (lineCount == 0) begin
      $display("Golden file holds no transactions");
      setupErrors++;
    end
    repeat (2) @(posedge drpClk);
    #1;
    rst   = 1'b0;
    first = 0;
    while (first < lineCount) begin
      last = first;
      while (last < lineCount && gold[last*Fields] == gold[first*Fields]) begin
        last++;
      end
      runGroup(first, last);
      first = last;
    end
    endOfTest = 1'b1;
    repeat (2) @(posedge drpClk);
    printErrorCounts();
    if (mismatchCount + otherCount + setupErrors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog scaled to the golden file length
  initial begin
    wait (lineCount > 0);
    repeat (lineCount * 40 + 200) @(posedge drpClk);
    $display("Timeout: run still busy after %0d cycles", lineCount * 40 + 200);
    printErrorCounts();
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== verification/drpChecker.sv ====
`timescale 1ns/100ps

module drpChecker #(
  parameter int NumPorts  = drpPkg::DEF_PORTS,
  parameter int AddrWidth = drpPkg::DEF_ADDR_W,
  parameter int DataWidth = drpPkg::DEF_DATA_W
) (
  input  logic                 drpClk,
  input  logic                 rst,
  input  logic [NumPorts-1:0]  sEn,
  input  drpPkg::drpReqT       sReq [NumPorts],
  input  logic [NumPorts-1:0]  sRdy,
  input  logic [DataWidth-1:0] sDo [NumPorts],
  input  logic                 mEn,
  input  logic                 mWe,
  input  logic [AddrWidth-1:0] mAddr,
  input  logic [DataWidth-1:0] mDo,
  input  logic                 mRdy,
  input  logic [DataWidth-1:0] mDi,
  input  logic                 endOfTest,
  output int                   mismatchCount,
  output int                   otherCount
);

  import drpPkg::*;

  // Reference model of the slots, pointer and held read data
  logic [NumPorts-1:0]  pend = '0;
  drpReqT               held [NumPorts];
  logic [DataWidth-1:0] expSdo [NumPorts];
  logic [NumPorts-1:0]  sdoKnown = '0;
  logic [DataWidth-1:0] rdData = '0;
  logic                 busy = 1'b0;
  logic                 rstPrev = 1'b0;
  logic                 endDone = 1'b0;
  int                   lastPtr = NumPorts - 1;
  int                   curPort = 0;
  int                   cycle = 0;
  int                   menDue = -1;
  int                   rdyDue = -1;
  int                   misCnt = 0;
  int                   othCnt = 0;

  assign mismatchCount = misCnt;
  assign otherCount    = othCnt;

  task automatic flagMismatch(string name, logic [31:0] expVal, logic [31:0] gotVal);
    misCnt++;
    $display("Mismatch %s exp %h got %h at %0t", name, expVal, gotVal, $time);
  endtask

  task automatic noteFailure(string msg);
    othCnt++;
    $display("%s at %0t", msg, $time);
  endtask

  // First pending port above the last grant, wrapping around
  function automatic int pickNext(logic [NumPorts-1:0] req, int last);
    int p;
    p = last;
    for (int k = 0; k < NumPorts; k++) begin
      p = (p + 1) % NumPorts;
      if (req[p]) begin
        return p;
      end
    end
    return -1;
  endfunction

  task automatic checkIssue();
    int expPort;
    expPort = pickNext(pend, lastPtr);
    if (menDue >= 0 && menDue != cycle) begin
      noteFailure($sformatf("mEn came %0d cycles after the strobe instead of 3",
                            cycle - menDue + 3));
    end
    menDue = -1;
    if (busy) begin
      noteFailure("Extra mEn while a transaction is outstanding");
    end else if (expPort < 0) begin
      noteFailure("Extra mEn with no request pending");
    end else begin
      if (mWe !== held[expPort].we) begin
        flagMismatch("mWe", 32'(held[expPort].we), 32'(mWe));
      end
      if (mAddr !== held[expPort].addr) begin
        flagMismatch("mAddr", 32'(held[expPort].addr), 32'(mAddr));
      end
      if (mDo !== held[expPort].di) begin
        flagMismatch("mDo", 32'(held[expPort].di), 32'(mDo));
      end
      pend[expPort] = 1'b0;
      lastPtr       = expPort;
      curPort       = expPort;
      busy          = 1'b1;
    end
  endtask

  task automatic checkResponse();
    logic [NumPorts-1:0] expRdy;
    expRdy          = '0;
    expRdy[curPort] = 1'b1;
    if (!busy) begin
      noteFailure($sformatf("Extra sRdy pulse %b with nothing outstanding", sRdy));
    end else begin
      if (rdyDue != cycle) begin
        noteFailure("sRdy did not follow mRdy by 2 cycles");
      end
      if (sRdy !== expRdy) begin
        flagMismatch("sRdy", 32'(expRdy), 32'(sRdy));
      end
      // Requesting port gets the new data, the others hold theirs
      for (int p = 0; p < NumPorts; p++) begin
        if (p == curPort && sDo[p] !== rdData) begin
          flagMismatch($sformatf("sDo[%0d]", p), 32'(rdData), 32'(sDo[p]));
        end else if (p != curPort && sdoKnown[p] && sDo[p] !== expSdo[p]) begin
          flagMismatch($sformatf("sDo[%0d]", p), 32'(expSdo[p]), 32'(sDo[p]));
        end
      end
      expSdo[curPort]   = rdData;
      sdoKnown[curPort] = 1'b1;
      busy              = 1'b0;
    end
    rdyDue = -1;
  endtask

  //////////////////////////////
  // Sampling at the falling edge
  //////////////////////////////

  always @(negedge drpClk) begin
    cycle++;
    if (rst) begin
      if (rstPrev && (mEn || sRdy != '0)) begin
        noteFailure("mEn or sRdy active while reset is held");
      end
      pend    = '0;
      busy    = 1'b0;
      lastPtr = NumPorts - 1;
      menDue  = -1;
      rdyDue  = -1;
    end else begin
      // Idle interconnect has a fixed strobe to issue latency
      if (sEn != '0 && pend == '0 && !busy) begin
        menDue = cycle + 3;
      end
      for (int p = 0; p < NumPorts; p++) begin
        if (sEn[p]) begin
          if (pend[p] || (busy && curPort == p)) begin
            noteFailure($sformatf("Port %0d strobed again before its sRdy", p));
          end
          pend[p] = 1'b1;
          held[p] = sReq[p];
        end
      end
      if (mEn) begin
        checkIssue();
      end else if (menDue == cycle) begin
        noteFailure("No mEn 3 cycles after a strobe on an idle interconnect");
        menDue = -1;
      end
      if (mRdy) begin
        if (!busy) begin
          noteFailure("Target ready with no transaction outstanding");
        end
        rdData = mDi;
        rdyDue = cycle + 2;
      end
      if (sRdy != '0) begin
        checkResponse();
      end else if (rdyDue == cycle) begin
        noteFailure("No sRdy 2 cycles after mRdy");
        busy   = 1'b0;
        rdyDue = -1;
      end
      if (endOfTest && !endDone) begin
        endDone = 1'b1;
        if (pend != '0 || busy) begin
          noteFailure("Requests still open at the end of the test");
        end
      end
    end
    rstPrev = rst;
  end

endmodule

// ==== src/drpInterconnect.sv ====
`timescale 1ns/100ps

module drpInterconnect #(
  parameter int NumPorts  = drpPkg::DEF_PORTS,
  parameter int AddrWidth = drpPkg::DEF_ADDR_W,
  parameter int DataWidth = drpPkg::DEF_DATA_W
) (
  input  logic                 drpClk,
  input  logic                 rst,
  // Slave ports
  input  logic [NumPorts-1:0]  sEn,
  input  drpPkg::drpReqT       sReq [NumPorts],
  output logic [NumPorts-1:0]  sRdy,
  output logic [DataWidth-1:0] sDo [NumPorts],
  // Master port towards the configurable block
  output logic                 mEn,
  output logic                 mWe,
  output logic [AddrWidth-1:0] mAddr,
  output logic [DataWidth-1:0] mDo,
  input  logic                 mRdy,
  input  logic [DataWidth-1:0] mDi
);

  import drpPkg::*;

  //////////////////////////////
  // Stage to stage wiring
  //////////////////////////////

  logic [NumPorts-1:0] pending;
  drpReqT              storedReq [NumPorts];
  logic                grant;
  portIdxT             grantPort;
  logic                seqIdle;
  logic                done;
  drpRspT              rsp;

  // Decode
  drpRequestLatch #(
    .NumPorts (NumPorts)
  ) i_drpRequestLatch (
    .drpClk    (drpClk),
    .rst       (rst),
    .sEn       (sEn),
    .sReq      (sReq),
    .grant     (grant),
    .grantPort (grantPort),
    .pending   (pending),
    .storedReq (storedReq)
  );

  drpArbiter #(
    .NumPorts (NumPorts)
  ) i_drpArbiter (
    .drpClk    (drpClk),
    .rst       (rst),
    .pending   (pending),
    .seqIdle   (seqIdle),
    .grant     (grant),
    .grantPort (grantPort)
  );

  // Execute
  drpMasterSequencer #(
    .NumPorts (NumPorts)
  ) i_drpMasterSequencer (
    .drpClk    (drpClk),
    .rst       (rst),
    .grant     (grant),
    .grantPort (grantPort),
    .storedReq (storedReq),
    .mRdy      (mRdy),
    .mDi       (mDi),
    .seqIdle   (seqIdle),
    .mEn       (mEn),
    .mWe       (mWe),
    .mAddr     (mAddr),
    .mDo       (mDo),
    .done      (done),
    .rsp       (rsp)
  );

  // Result
  drpResponseRouter #(
    .NumPorts (NumPorts)
  ) i_drpResponseRouter (
    .drpClk (drpClk),
    .rst    (rst),
    .done   (done),
    .rsp    (rsp),
    .sRdy   (sRdy),
    .sDo    (sDo)
  );

endmodule

// ==== src/drpResponseRouter.sv ====
`timescale 1ns/100ps

module drpResponseRouter #(
  parameter int NumPorts = drpPkg::DEF_PORTS
) (
  input  logic                drpClk,
  input  logic                rst,
  input  logic                done,
  input  drpPkg::drpRspT      rsp,
  output logic [NumPorts-1:0] sRdy,
  output drpPkg::drpDataT     sDo [NumPorts]
);

  import drpPkg::*;

  // One-hot decode of the returning port
  logic [NumPorts-1:0] portHit;

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      portHit[p] = done && (rsp.port == portIdxT'(p));
    end
  end

  //////////////////////////////
  // Ready pulse
  //////////////////////////////

  always_ff @(posedge drpClk) begin
    if (rst) begin
      sRdy <= '0;
    end else begin
      sRdy <= portHit;
    end
  end

  //////////////////////////////
  // Held read data
  //////////////////////////////

  // Other ports keep their last value
  always_ff @(posedge drpClk) begin
    for (int p = 0; p < NumPorts; p++) begin
      if (portHit[p]) begin
        sDo[p] <= rsp.dout;
      end
    end
  end

endmodule

// ==== drpMaster/drpMasterSequencer.sv ====
`timescale 1ns/100ps

module drpMasterSequencer #(
  parameter int NumPorts = drpPkg::DEF_PORTS
) (
  input  logic            drpClk,
  input  logic            rst,
  input  logic            grant,
  input  drpPkg::portIdxT grantPort,
  input  drpPkg::drpReqT  storedReq [NumPorts],
  input  logic            mRdy,
  input  drpPkg::drpDataT mDi,
  output logic            seqIdle,
  output logic            mEn,
  output logic            mWe,
  output drpPkg::drpAddrT mAddr,
  output drpPkg::drpDataT mDo,
  output logic            done,
  output drpPkg::drpRspT  rsp
);

  import drpPkg::*;

  seqStateT state;

  logic   takeGrant;
  logic   rdyHit;
  drpReqT grantedReq;

  assign takeGrant  = (state == IDLE) && grant;
  assign rdyHit     = (state == WAIT) && mRdy;
  assign grantedReq = storedReq[grantPort];
  assign seqIdle    = (state == IDLE);

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  // mEn is high while in ISSUE, done is high while in DONE
  always_ff @(posedge drpClk) begin
    if (rst) begin
      state <= IDLE;
      mEn   <= 1'b0;
      done  <= 1'b0;
    end else begin
      mEn  <= 1'b0;
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (takeGrant) begin
            state <= ISSUE;
            mEn   <= 1'b1;
          end
        end
        ISSUE: begin
          state <= WAIT;
        end
        WAIT: begin
          // Target may take any number of cycles
          if (rdyHit) begin
            state <= DONE;
            done  <= 1'b1;
          end
        end
        DONE: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Master port and response data
  //////////////////////////////

  always_ff @(posedge drpClk) begin
    if (takeGrant) begin
      mWe      <= grantedReq.we;
      mAddr    <= grantedReq.addr;
      mDo      <= grantedReq.di;
      rsp.port <= grantPort;
    end
    // Read data is captured for writes too, the slave ignores it
    if (rdyHit) begin
      rsp.dout <= mDi;
    end
  end

endmodule

// ==== drpMaster/drpArbiter.sv ====
`timescale 1ns/100ps

module drpArbiter #(
  parameter int NumPorts = drpPkg::DEF_PORTS
) (
  input  logic                drpClk,
  input  logic                rst,
  input  logic [NumPorts-1:0] pending,
  input  logic                seqIdle,
  output logic                grant,
  output drpPkg::portIdxT     grantPort
);

  import drpPkg::*;

  // Port of the most recent grant
  portIdxT lastPtr;

  portIdxT nextPort;
  logic    anyPending;

  //////////////////////////////
  // Round-robin search
  //////////////////////////////

  // Walk upward from the port after the last grant, wrapping around
  always_comb begin
    int unsigned cand;
    nextPort   = lastPtr;
    anyPending = 1'b0;
    for (int k = 1; k <= NumPorts; k++) begin
      cand = (int'(lastPtr) + k) % NumPorts;
      if (!anyPending && pending[cand]) begin
        anyPending = 1'b1;
        nextPort   = portIdxT'(cand);
      end
    end
  end

  //////////////////////////////
  // Grant strobe and pointer
  //////////////////////////////

  // Pointer starts at the top port so port 0 wins first.
  // A grant is never issued back to back since the sequencer
  // only leaves IDLE on the edge after the strobe
  always_ff @(posedge drpClk) begin
    if (rst) begin
      grant   <= 1'b0;
      lastPtr <= portIdxT'(NumPorts - 1);
    end else begin
      grant <= 1'b0;
      if (seqIdle && !grant && anyPending) begin
        grant   <= 1'b1;
        lastPtr <= nextPort;
      end
    end
  end

  // Pointer already holds the granted port during the strobe
  assign grantPort = lastPtr;

endmodule

// ==== src/drpRequestLatch.sv ====
`timescale 1ns/100ps

module drpRequestLatch #(
  parameter int NumPorts = drpPkg::DEF_PORTS
) (
  input  logic                drpClk,
  input  logic                rst,
  input  logic [NumPorts-1:0] sEn,
  input  drpPkg::drpReqT      sReq [NumPorts],
  input  logic                grant,
  input  drpPkg::portIdxT     grantPort,
  output logic [NumPorts-1:0] pending,
  output drpPkg::drpReqT      storedReq [NumPorts]
);

  import drpPkg::*;

  // One bit per port, high when the arbiter takes that slot this cycle
  logic [NumPorts-1:0] grantHit;

  //////////////////////////////
  // Grant decode
  //////////////////////////////

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      grantHit[p] = grant && (grantPort == portIdxT'(p));
    end
  end

  //////////////////////////////
  // Request slots
  //////////////////////////////

  // Loaded on the enable strobe and held until the next one
  always_ff @(posedge drpClk) begin
    for (int p = 0; p < NumPorts; p++) begin
      if (sEn[p]) begin
        storedReq[p] <= sReq[p];
      end
    end
  end

  //////////////////////////////
  // Pending flags
  //////////////////////////////

  // A slave may not strobe again before its ready pulse,
  // so set and clear never meet on the same port
  always_ff @(posedge drpClk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        if (sEn[p]) begin
          pending[p] <= 1'b1;
        end else if (grantHit[p]) begin
          pending[p] <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== common/drpPkg.sv ====
package drpPkg;

  //////////////////////////////
  // Default top-level parameter values
  //////////////////////////////

  localparam int DEF_PORTS  = 3;
  localparam int DEF_ADDR_W = 12;
  localparam int DEF_DATA_W = 16;

  //////////////////////////////
  // Plain vector types
  //////////////////////////////

  // DRP register address
  typedef logic [DEF_ADDR_W-1:0] drpAddrT;

  // DRP write or read data
  typedef logic [DEF_DATA_W-1:0] drpDataT;

  // Slave port number
  typedef logic [1:0] portIdxT;

  //////////////////////////////
  // Transaction structs
  //////////////////////////////

  // One DRP request as strobed by a slave
  typedef struct packed {
    logic    we;
    drpAddrT addr;
    drpDataT di;
  } drpReqT;

  // Completed transaction on its way back to a slave
  typedef struct packed {
    portIdxT port;
    drpDataT dout;
  } drpRspT;

  // Master port sequencer states
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT,
    DONE
  } seqStateT;

endpackage
